/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cpu_interface
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "run FAILED, see $(LOG)"; exit 1; \
	elif grep -q "Simulation passed" $(LOG); then \
		echo "run PASSED"; \
	else \
		echo "run FAILED, no result in $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/cpu_interface_asserts.sv */
`timescale 1ns/1ps

module cpu_interface_asserts
    import mem_map_pkg::*;
    import cache_pkg::*;
(
    input logic      cache_stall,
    input logic      rst,
    input dmem_req_t dmem_req,
    input apb_req_t  apb_req,
    input logic      pready,
    input logic      mem_stall,
    input logic      miss_busy,
    input logic      text_wr,
    input logic      text_stall,
    input logic      text_we
);

    int unsigned fail_count = 0;

    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] paddr;
    logic [31:0] pwdata;
    logic        trap_hit;

    assign psel    = apb_req.psel;
    assign penable = apb_req.penable;
    assign pwrite  = apb_req.pwrite;
    assign paddr   = apb_req.paddr;
    assign pwdata  = apb_req.pwdata;

    // region d with the trap tag
    assign trap_hit = (dmem_req.addr[29:26] == 4'hd) && (dmem_req.addr[25:18] == TRAP_TAG)
                      && (dmem_req.read || dmem_req.write);

    ////////////////////
    // apb protocol
    ////////////////////

    setup_then_access: assert property (@(posedge cache_stall) disable iff (!rst)
        psel && !penable |=> psel && penable)
        else begin
            fail_count++;
            $error("APB setup phase was not followed by an access phase");
        end

    // the miss stall only drops right after a completed transfer
    stall_falls_after_done: assert property (@(posedge cache_stall) disable iff (!rst)
        $fell(miss_busy) |-> $past(psel && penable && pready))
        else begin
            fail_count++;
            $error("cache stall dropped without a completed APB transfer");
        end

    hold_while_waiting: assert property (@(posedge cache_stall) disable iff (!rst)
        psel && penable && !pready |=> psel && penable && $stable(paddr)
            && $stable(pwdata) && $stable(pwrite))
        else begin
            fail_count++;
            $error("APB signals changed while pready was low");
        end

    // a write transfer ends the miss stall on the next cycle
    stall_ends_after_write: assert property (@(posedge cache_stall) disable iff (!rst)
        psel && penable && pready && pwrite |=> !miss_busy && !psel)
        else begin
            fail_count++;
            $error("cache stall still high after the APB write completed");
        end

    ////////////////////
    // stall sources
    ////////////////////

    text_stall_three: assert property (@(posedge cache_stall) disable iff (!rst)
        text_wr && $fell(text_stall) |-> $past(text_stall, 2) && $past(text_stall, 3)
            && !$past(text_wr, 4))
        else begin
            fail_count++;
            $error("text write stall did not last exactly three cycles");
        end

    text_we_once: assert property (@(posedge cache_stall) disable iff (!rst)
        text_wr && $fell(text_stall) |-> $past(text_we, 2) && !$past(text_we, 1)
            && !$past(text_we, 3) && !text_we)
        else begin
            fail_count++;
            $error("text write enable did not pulse exactly once");
        end

    trap_holds_stall: assert property (@(posedge cache_stall) disable iff (!rst)
        trap_hit |-> mem_stall)
        else begin
            fail_count++;
            $error("trap window access without a pipeline stall");
        end

endmodule

bind cpu_interface cpu_interface_asserts i_asserts (
    .cache_stall (cache_stall),
    .rst         (rst),
    .dmem_req    (dmem_req),
    .apb_req     (apb_req),
    .pready      (pready),
    .mem_stall   (mem_stall),
    .miss_busy   (miss_busy),
    .text_wr     (text_wr),
    .text_stall  (text_stall),
    .text_we     (i_text_mem_writer.text_we)
);

/* dv/tb_cpu_interface.sv */
`timescale 1ns/1ps

module tb_cpu_interface
    import mem_map_pkg::*;
    import cache_pkg::*;
;

    localparam int TRACE_DEPTH    = 16;
    localparam int MODEL_WORDS    = 64;
    localparam int CACHE_OPS      = 100;
    localparam int MAX_OPS        = 200;
    localparam int CYCLES_PER_OP  = 20;
    localparam int TIMEOUT_CYCLES = MAX_OPS * CYCLES_PER_OP;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    logic        cache_stall;
    logic        rst = 1'b0;
    dmem_req_t   dmem_req = '0;
    logic [29:0] fetch_addr = '0;
    logic [31:0] prdata = '0;
    logic        pready = 1'b0;
    logic [31:0] dmem_rdata;
    logic [31:0] fetch_rdata;
    logic        mem_stall;
    apb_req_t    apb_req;

    logic [31:0] lfsr_state = 32'he7cf3a82;
    logic [31:0] apb_mem [MODEL_WORDS];
    int          errors = 0;
    int          cycle_count = 0;

    cpu_interface #(
        .CACHE_LINES  (16),
        .TRACE_DEPTH  (TRACE_DEPTH),
        .LOADER_WORDS (256),
        .TEXT_BYTES   (1024)
    ) i_dut (
        .cache_stall (cache_stall),
        .rst         (rst),
        .dmem_req    (dmem_req),
        .fetch_addr  (fetch_addr),
        .dmem_rdata  (dmem_rdata),
        .fetch_rdata (fetch_rdata),
        .mem_stall   (mem_stall),
        .apb_req     (apb_req),
        .prdata      (prdata),
        .pready      (pready)
    );

    initial begin
        cache_stall = 1'b0;
        forever #50 cache_stall = ~cache_stall;
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ LFSR_TAPS;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return value;
    endfunction

    function automatic logic [31:0] fill_word(input int addr);
        return 32'hc3a50000 ^ (32'(addr) * 32'h01010107) ^ {8'(addr), 24'h0};
    endfunction

    function automatic logic [31:0] apply_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  be);
        logic [31:0] mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    task automatic check_word(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("Error at %0t: %s got %08h expected %08h", $time, what, got, exp);
        end
    endtask

    // present one request and hold it until the stall clears
    task automatic run_op(input dmem_req_t req, output logic [31:0] got, output int stalls);
        logic busy;
        stalls = 0;
        busy = 1'b1;
        @(posedge cache_stall);
        dmem_req <= req;
        while (busy) begin
            @(negedge cache_stall);
            busy = mem_stall;
            if (busy) begin
                stalls++;
            end
        end
        got = dmem_rdata;
    endtask

    task automatic idle_cycle();
        @(posedge cache_stall);
        dmem_req <= '0;
        @(negedge cache_stall);
    endtask

    task automatic fetch_word(input logic [29:0] addr, output logic [31:0] got);
        @(posedge cache_stall);
        fetch_addr <= addr;
        @(negedge cache_stall);
        got = fetch_rdata;
    endtask

    ////////////////////
    // apb slave model
    ////////////////////

    initial begin
        apb_req_t seen;
        int       wait_left;
        wait_left = 0;
        for (int i = 0; i < MODEL_WORDS; i++) begin
            apb_mem[i] = fill_word(i);
        end
        forever begin
            @(negedge cache_stall);
            seen = apb_req;
            @(posedge cache_stall);
            if (seen.psel && !seen.penable) begin
                wait_left = int'(take_bits(2));
                pready <= (wait_left == 0);
            end else if (seen.psel && seen.penable && !pready) begin
                wait_left--;
                pready <= (wait_left == 0);
            end else begin
                if (seen.psel && seen.penable && seen.pwrite) begin
                    apb_mem[seen.paddr[7:2]] = seen.pwdata;
                end
                pready <= 1'b0;
            end
            if (seen.psel) begin
                prdata <= apb_mem[seen.paddr[7:2]];
            end
        end
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge cache_stall);
            cycle_count++;
        end
        $display("Timeout: run stopped after %0d cycles", cycle_count);
        $display("Simulation failed");
        $finish;
    end

    ////////////////////
    // test sequence
    ////////////////////

    initial begin
        dmem_req_t   req;
        logic [31:0] ref_mem [MODEL_WORDS];
        logic [31:0] got;
        logic [31:0] data;
        logic [5:0]  idx;
        logic [7:0]  word;
        logic [3:0]  region;
        int          stalls;
        int          miss_cycles;
        int          hold;
        int unsigned assert_fails;

        miss_cycles = 0;
        for (int i = 0; i < MODEL_WORDS; i++) begin
            ref_mem[i] = fill_word(i);
        end
        repeat (4) @(posedge cache_stall);
        rst <= 1'b1;
        @(negedge cache_stall);

        // random cache traffic against the reference memory
        for (int n = 0; n < CACHE_OPS; n++) begin
            idx = 6'(take_bits(6));
            req = '0;
            req.addr = 30'(idx);
            if (take_bits(1) == 1) begin
                req.write   = 1'b1;
                req.wdata   = take_bits(32);
                req.byte_en = 4'(take_bits(4));
                if (req.byte_en == 4'h0) begin
                    req.byte_en = 4'hf;
                end
            end else begin
                req.read = 1'b1;
            end
            run_op(req, got, stalls);
            miss_cycles += stalls;
            if (req.read) begin
                check_word("dmem_rdata", got, ref_mem[idx]);
            end else begin
                ref_mem[idx] = apply_bytes(ref_mem[idx], req.wdata, req.byte_en);
            end
            idle_cycle();
        end

        // trace end pointer counts every stalled miss cycle
        req = '0;
        req.read = 1'b1;
        req.addr = {4'hd, TRACE_END_ADDR};
        run_op(req, got, stalls);
        check_word("trace end dmem_rdata", got, 32'(miss_cycles % TRACE_DEPTH));
        idle_cycle();

        for (int n = 0; n < 8; n++) begin
            req = '0;
            req.write   = 1'b1;
            req.addr    = {4'hc, 26'(take_bits(8))};
            req.wdata   = take_bits(32);
            req.byte_en = 4'(4'b0001 << take_bits(2));
            run_op(req, got, stalls);
            assert (stalls == 3) else begin
                errors++;
                $display("Error at %0t: text mem_stall cycles got %0d expected 3",
                         $time, stalls);
            end
            idle_cycle();
        end

        // trap window stays stalled until the request drops
        for (int n = 0; n < 4; n++) begin
            req = '0;
            req.read = 1'b1;
            req.addr = {4'hd, TRAP_TAG, 18'(take_bits(18))};
            hold = 2 + int'(take_bits(3));
            @(posedge cache_stall);
            dmem_req <= req;
            repeat (hold) begin
                @(negedge cache_stall);
                assert (mem_stall) else begin
                    errors++;
                    $display("Error at %0t: mem_stall got 0 expected 1", $time);
                end
            end
            idle_cycle();
        end

        for (int n = 0; n < 16; n++) begin
            word = 8'(take_bits(8));
            data = take_bits(32);
            req = '0;
            req.write   = 1'b1;
            req.addr    = {4'hf, 18'h0, word};
            req.wdata   = data;
            req.byte_en = 4'hf;
            run_op(req, got, stalls);
            idle_cycle();
            req.write = 1'b0;
            req.read  = 1'b1;
            run_op(req, got, stalls);
            check_word("loader dmem_rdata", got, data);
            idle_cycle();
            fetch_word({4'hf, 18'h0, word}, got);
            check_word("fetch_rdata", got, data);
            region = 4'(take_bits(4));
            if (region == 4'hf) begin
                region = 4'h0;
            end
            fetch_word({region, 18'h0, word}, got);
            check_word("fetch_rdata outside loader", got, 32'h0);
        end

        for (int n = 0; n < 4; n++) begin
            req = '0;
            req.read = 1'b1;
            req.addr = {4'he, 26'(take_bits(26))};
            run_op(req, got, stalls);
            check_word("keyboard dmem_rdata", got, 32'h0);
            idle_cycle();
        end

        // let the last properties finish
        repeat (5) idle_cycle();
        assert_fails = i_dut.i_asserts.fail_count;
        $display("checks done: %0d data errors, %0d assertion failures", errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* flist.f */
rtl/mem_map_pkg.sv
rtl/cache_pkg.sv
rtl/region_decode.sv
rtl/dcache.sv
rtl/text_mem_writer.sv
rtl/loader_mem.sv
rtl/trace_queue.sv
rtl/cpu_interface.sv
dv/cpu_interface_asserts.sv
dv/tb_cpu_interface.sv

/* rtl/cache_pkg.sv */
package cache_pkg;

    ////////////////////
    // cache controller
    ////////////////////

    // apb transfer phases, done is the one cycle after completion
    typedef enum logic [1:0] {
        C_IDLE,
        C_SETUP,
        C_ACCESS,
        C_DONE
    } cache_state_e;

    // apb master outputs
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    ////////////////////
    // miss trace
    ////////////////////

    // one record per stalled miss cycle
    typedef struct packed {
        logic [29:0] addr;
        logic        write;
        logic [6:0]  miss_num;
        logic [7:0]  cycle;
    } trace_entry_t;

endpackage

/* rtl/cpu_interface.sv */
`timescale 1ns/1ps

module cpu_interface
    import mem_map_pkg::*;
    import cache_pkg::*;
#(
    parameter int CACHE_LINES  = 16,
    parameter int TRACE_DEPTH  = 16,
    parameter int LOADER_WORDS = 256,
    parameter int TEXT_BYTES   = 1024
) (
    input  logic        cache_stall,
    input  logic        rst,
    input  dmem_req_t   dmem_req,
    input  logic [29:0] fetch_addr,
    output logic [31:0] dmem_rdata,
    output logic [31:0] fetch_rdata,
    output logic        mem_stall,
    output apb_req_t    apb_req,
    input  logic [31:0] prdata,
    input  logic        pready
);

    localparam int LOADER_AW = $clog2(LOADER_WORDS);

    dmem_req_t            cache_req;
    logic [31:0]          cache_rdata;
    logic [31:0]          loader_rdata;
    logic [31:0]          loader_fetch;
    logic [31:0]          trace_rdata;
    logic [25:0]          trace_addr;
    logic                 text_wr;
    logic                 text_stall;
    logic                 loader_en;
    logic                 loader_we;
    logic                 trap_stall;
    logic                 miss_busy;
    logic [29:0]          miss_addr;
    logic [LOADER_AW-1:0] loader_addr;

    assign mem_stall = miss_busy | text_stall | trap_stall;

    // park the loader data port when the region is not selected
    assign loader_addr = loader_en ? dmem_req.addr[LOADER_AW-1:0] : '0;

    region_decode i_region_decode (
        .dmem_req     (dmem_req),
        .fetch_addr   (fetch_addr),
        .cache_rdata  (cache_rdata),
        .loader_rdata (loader_rdata),
        .loader_fetch (loader_fetch),
        .trace_rdata  (trace_rdata),
        .cache_req    (cache_req),
        .text_wr      (text_wr),
        .trace_addr   (trace_addr),
        .loader_en    (loader_en),
        .loader_we    (loader_we),
        .trap_stall   (trap_stall),
        .dmem_rdata   (dmem_rdata),
        .fetch_rdata  (fetch_rdata)
    );

    dcache #(.CACHE_LINES(CACHE_LINES)) i_dcache (
        .cache_stall (cache_stall),
        .rst         (rst),
        .cache_req   (cache_req),
        .prdata      (prdata),
        .pready      (pready),
        .apb_req     (apb_req),
        .rdata       (cache_rdata),
        .miss_busy   (miss_busy),
        .miss_addr   (miss_addr)
    );

    text_mem_writer #(.TEXT_BYTES(TEXT_BYTES)) i_text_mem_writer (
        .cache_stall (cache_stall),
        .rst         (rst),
        .text_wr     (text_wr),
        .addr        (dmem_req.addr),
        .wdata       (dmem_req.wdata),
        .byte_en     (dmem_req.byte_en),
        .text_stall  (text_stall)
    );

    loader_mem #(.LOADER_WORDS(LOADER_WORDS)) i_loader_mem (
        .cache_stall (cache_stall),
        .loader_we   (loader_we),
        .addr        (loader_addr),
        .wdata       (dmem_req.wdata),
        .rdata       (loader_rdata),
        .fetch_addr  (fetch_addr[LOADER_AW-1:0]),
        .fetch_data  (loader_fetch)
    );

    // cpu holds the request during a miss, so its write flag is the miss type
    trace_queue #(.TRACE_DEPTH(TRACE_DEPTH)) i_trace_queue (
        .cache_stall (cache_stall),
        .rst         (rst),
        .miss_busy   (miss_busy),
        .miss_addr   (miss_addr),
        .miss_write  (cache_req.write),
        .trace_addr  (trace_addr),
        .trace_rdata (trace_rdata)
    );

endmodule

/* rtl/dcache.sv */
`timescale 1ns/1ps

module dcache
    import mem_map_pkg::*;
    import cache_pkg::*;
#(
    parameter int CACHE_LINES = 16
) (
    input  logic        cache_stall,
    input  logic        rst,
    input  dmem_req_t   cache_req,
    input  logic [31:0] prdata,
    input  logic        pready,
    output apb_req_t    apb_req,
    output logic [31:0] rdata,
    output logic        miss_busy,
    output logic [29:0] miss_addr
);

    localparam int IDX_W = $clog2(CACHE_LINES);
    localparam int TAG_W = 30 - IDX_W;

    logic [31:0]            line_data  [CACHE_LINES];
    logic [TAG_W-1:0]       line_tag   [CACHE_LINES];
    logic [CACHE_LINES-1:0] line_valid;

    cache_state_e state;
    logic [29:0]  addr_q;
    logic [31:0]  wdata_q;
    logic [3:0]   be_q;
    logic         pwrite_q;
    logic         wr_hit_q;
    logic         rmw_q;

    logic [IDX_W-1:0] req_idx;
    logic [IDX_W-1:0] fill_idx;
    logic [TAG_W-1:0] req_tag;
    logic             hit;
    logic             start;
    logic             done;

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  be);
        logic [31:0] result;
        result = old_word;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                result[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return result;
    endfunction

    assign req_idx  = cache_req.addr[IDX_W-1:0];
    assign req_tag  = cache_req.addr[29:IDX_W];
    assign fill_idx = addr_q[IDX_W-1:0];
    assign hit      = line_valid[req_idx] && (line_tag[req_idx] == req_tag);

    // writes always go out, reads only on a miss
    assign start = cache_req.write || (cache_req.read && !hit);
    assign done  = (state == C_ACCESS) && pready;

    assign rdata     = line_data[req_idx];
    assign miss_busy = ((state == C_IDLE) && start) || (state == C_SETUP) || (state == C_ACCESS);
    assign miss_addr = (state == C_IDLE) ? cache_req.addr : addr_q;

    assign apb_req.psel    = (state == C_SETUP) || (state == C_ACCESS);
    assign apb_req.penable = (state == C_ACCESS);
    assign apb_req.pwrite  = pwrite_q;
    assign apb_req.paddr   = {addr_q, 2'b00};
    assign apb_req.pwdata  = wdata_q;

    ////////////////////
    // transfer FSM
    ////////////////////

    always_ff @(posedge cache_stall) begin
        if (!rst) begin
            state      <= C_IDLE;
            pwrite_q   <= 1'b0;
            wr_hit_q   <= 1'b0;
            rmw_q      <= 1'b0;
            line_valid <= '0;
        end else begin
            case (state)
                C_IDLE: begin
                    if (start) begin
                        state    <= C_SETUP;
                        wr_hit_q <= cache_req.write && hit;
                        // partial write miss reads the word first
                        rmw_q    <= cache_req.write && !hit && (cache_req.byte_en != 4'hf);
                        pwrite_q <= cache_req.write && (hit || cache_req.byte_en == 4'hf);
                    end
                end
                C_SETUP: begin
                    state <= C_ACCESS;
                end
                C_ACCESS: begin
                    if (pready) begin
                        if (rmw_q) begin
                            rmw_q    <= 1'b0;
                            pwrite_q <= 1'b1;
                            state    <= C_SETUP;
                        end else begin
                            state <= C_DONE;
                            if (!pwrite_q) begin
                                line_valid[fill_idx] <= 1'b1;
                            end
                        end
                    end
                end
                default: begin
                    state <= C_IDLE;
                end
            endcase
        end
    end

    ////////////////////
    // lines and payload
    ////////////////////

    always_ff @(posedge cache_stall) begin
        if ((state == C_IDLE) && start) begin
            addr_q  <= cache_req.addr;
            be_q    <= cache_req.byte_en;
            wdata_q <= hit ? merge_bytes(line_data[req_idx], cache_req.wdata, cache_req.byte_en)
                           : cache_req.wdata;
        end
        if (done && rmw_q) begin
            wdata_q <= merge_bytes(prdata, wdata_q, be_q);
        end
        // fill on read completion
        if (done && !pwrite_q && !rmw_q) begin
            line_data[fill_idx] <= prdata;
            line_tag[fill_idx]  <= addr_q[29:IDX_W];
        end
        if (done && pwrite_q && wr_hit_q) begin
            line_data[fill_idx] <= wdata_q;
        end
    end

endmodule

/* rtl/loader_mem.sv */
`timescale 1ns/1ps

module loader_mem #(
    parameter int LOADER_WORDS = 256
) (
    input  logic                            cache_stall,
    input  logic                            loader_we,
    input  logic [$clog2(LOADER_WORDS)-1:0] addr,
    input  logic [31:0]                     wdata,
    output logic [31:0]                     rdata,
    input  logic [$clog2(LOADER_WORDS)-1:0] fetch_addr,
    output logic [31:0]                     fetch_data
);

    logic [31:0] ram [LOADER_WORDS];

    // data port write
    always_ff @(posedge cache_stall) begin
        if (loader_we) begin
            ram[addr] <= wdata;
        end
    end

    // both read ports asynchronous
    assign rdata      = ram[addr];
    assign fetch_data = ram[fetch_addr];

endmodule

/* rtl/mem_map_pkg.sv */
package mem_map_pkg;

    ////////////////////
    // address regions
    ////////////////////

    // word address bits 29..26 pick the region
    localparam int REGION_MSB = 29;
    localparam int REGION_LSB = 26;

    typedef enum logic [3:0] {
        REG_CACHE  = 4'h0,
        REG_TEXT   = 4'hc,
        REG_DEBUG  = 4'hd,
        REG_KBD    = 4'he,
        REG_LOADER = 4'hf
    } region_e;

    // trap window inside region d, bits 25..18
    localparam logic [7:0] TRAP_TAG = 8'hdd;

    // trace queue pointer offsets inside region d
    localparam logic [25:0] TRACE_START_ADDR = 26'h3000001;
    localparam logic [25:0] TRACE_END_ADDR   = 26'h3000002;

    // cpu data port request
    typedef struct packed {
        logic        read;
        logic        write;
        logic [29:0] addr;
        logic [31:0] wdata;
        logic [3:0]  byte_en;
    } dmem_req_t;

    function automatic region_e region_of(input logic [29:0] addr);
        case (addr[REGION_MSB:REGION_LSB])
            4'hc:    return REG_TEXT;
            4'hd:    return REG_DEBUG;
            4'he:    return REG_KBD;
            4'hf:    return REG_LOADER;
            default: return REG_CACHE;
        endcase
    endfunction

endpackage

/* rtl/region_decode.sv */
`timescale 1ns/1ps

module region_decode
    import mem_map_pkg::*;
(
    input  dmem_req_t   dmem_req,
    input  logic [29:0] fetch_addr,
    input  logic [31:0] cache_rdata,
    input  logic [31:0] loader_rdata,
    input  logic [31:0] loader_fetch,
    input  logic [31:0] trace_rdata,
    output dmem_req_t   cache_req,
    output logic        text_wr,
    output logic [25:0] trace_addr,
    output logic        loader_en,
    output logic        loader_we,
    output logic        trap_stall,
    output logic [31:0] dmem_rdata,
    output logic [31:0] fetch_rdata
);

    region_e data_region;
    region_e fetch_region;

    assign data_region  = region_of(dmem_req.addr);
    assign fetch_region = region_of(fetch_addr);

    always_comb begin
        // defaults leave every memory untouched
        cache_req  = '0;
        text_wr    = 1'b0;
        trace_addr = '0;
        loader_en  = 1'b0;
        loader_we  = 1'b0;
        trap_stall = 1'b0;
        dmem_rdata = '0;

        case (data_region)
            REG_TEXT: begin
                text_wr = dmem_req.write;
            end
            REG_DEBUG: begin
                if (dmem_req.addr[25:18] == TRAP_TAG) begin
                    trap_stall = dmem_req.read | dmem_req.write;
                end else begin
                    trace_addr = dmem_req.addr[25:0];
                    dmem_rdata = trace_rdata;
                end
            end
            REG_KBD: begin
                // no keyboard behind this, reads zero
                dmem_rdata = '0;
            end
            REG_LOADER: begin
                loader_en  = 1'b1;
                loader_we  = dmem_req.write;
                dmem_rdata = loader_rdata;
            end
            default: begin
                cache_req  = dmem_req;
                dmem_rdata = cache_rdata;
            end
        endcase

        // only the loader holds code
        fetch_rdata = (fetch_region == REG_LOADER) ? loader_fetch : '0;
    end

endmodule

/* rtl/text_mem_writer.sv */
`timescale 1ns/1ps

module text_mem_writer #(
    parameter int TEXT_BYTES = 1024
) (
    input  logic        cache_stall,
    input  logic        rst,
    input  logic        text_wr,
    input  logic [29:0] addr,
    input  logic [31:0] wdata,
    input  logic [3:0]  byte_en,
    output logic        text_stall
);

    localparam int BA_W = $clog2(TEXT_BYTES);

    logic [7:0]      text_ram [TEXT_BYTES];
    logic [1:0]      wr_cnt;
    logic            text_we;
    logic [1:0]      lane;
    logic [7:0]      char_data;
    logic [BA_W-1:0] byte_addr;

    // one-hot lane select, msb enable is byte 0
    always_comb begin
        case (byte_en)
            4'b1000: begin
                lane      = 2'd0;
                char_data = wdata[7:0];
            end
            4'b0100: begin
                lane      = 2'd1;
                char_data = wdata[15:8];
            end
            4'b0010: begin
                lane      = 2'd2;
                char_data = wdata[23:16];
            end
            default: begin
                lane      = 2'd3;
                char_data = wdata[31:24];
            end
        endcase
    end

    assign byte_addr  = {addr[BA_W-3:0], lane};
    assign text_we    = text_wr && (wr_cnt == 2'd1);
    assign text_stall = text_wr && (wr_cnt < 2'd3);

    // counter sits at 3 until the request goes away
    always_ff @(posedge cache_stall) begin
        if (!rst || !text_wr) begin
            wr_cnt <= 2'd0;
        end else if (wr_cnt < 2'd3) begin
            wr_cnt <= wr_cnt + 2'd1;
        end
    end

    always_ff @(posedge cache_stall) begin
        if (text_we) begin
            text_ram[byte_addr] <= char_data;
        end
    end

endmodule

/* rtl/trace_queue.sv */
`timescale 1ns/1ps

module trace_queue
    import mem_map_pkg::*;
    import cache_pkg::*;
#(
    parameter int TRACE_DEPTH = 16
) (
    input  logic        cache_stall,
    input  logic        rst,
    input  logic        miss_busy,
    input  logic [29:0] miss_addr,
    input  logic        miss_write,
    input  logic [25:0] trace_addr,
    output logic [31:0] trace_rdata
);

    localparam int PTR_W   = $clog2(TRACE_DEPTH);
    localparam int ENTRY_W = $bits(trace_entry_t);

    trace_entry_t     queue [TRACE_DEPTH];
    trace_entry_t     new_entry;
    trace_entry_t     rd_entry;
    logic [PTR_W-1:0] start_ptr;
    logic [PTR_W-1:0] end_ptr;
    logic             in_miss;
    logic [6:0]       miss_num;
    logic [7:0]       miss_cycle;
    logic             first_cycle;

    assign first_cycle = miss_busy && !in_miss;

    always_comb begin
        new_entry.addr     = miss_addr;
        new_entry.write    = miss_write;
        new_entry.miss_num = first_cycle ? miss_num + 7'd1 : miss_num;
        new_entry.cycle    = first_cycle ? 8'd0 : miss_cycle;
    end

    always_ff @(posedge cache_stall) begin
        if (!rst) begin
            start_ptr  <= '0;
            end_ptr    <= '0;
            in_miss    <= 1'b0;
            miss_num   <= '0;
            miss_cycle <= '0;
        end else begin
            in_miss <= miss_busy;
            if (miss_busy) begin
                // wraps and overwrites the oldest record
                end_ptr    <= end_ptr + 1'b1;
                miss_num   <= new_entry.miss_num;
                miss_cycle <= new_entry.cycle + 8'd1;
                if (first_cycle) begin
                    start_ptr <= end_ptr;
                end
            end
        end
    end

    always_ff @(posedge cache_stall) begin
        if (miss_busy) begin
            queue[end_ptr] <= new_entry;
        end
    end

    // bit 0 picks the entry half
    assign rd_entry = queue[trace_addr[PTR_W:1]];

    always_comb begin
        if (trace_addr == TRACE_START_ADDR) begin
            trace_rdata = 32'(start_ptr);
        end else if (trace_addr == TRACE_END_ADDR) begin
            trace_rdata = 32'(end_ptr);
        end else if (trace_addr[0]) begin
            trace_rdata = 32'(rd_entry[ENTRY_W-1:32]);
        end else begin
            trace_rdata = rd_entry[31:0];
        end
    end

endmodule
